/* rtl/frontend_defs.svh */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// address and instruction width
`define XLEN 32

// one memory line and the beats that fill it
`define LINE_W 256
`define BEAT_W 64
`define BEATS_PER_LINE 4

// fetch sequence number
`define ORDER_W 64

// power-of-two number of instruction queue entries
`define IQ_DEPTH 8

`define FETCH_RESET_PC 32'haaaaa000

`endif

/* rtl/frontend_pkg.sv */
`default_nettype none

`include "frontend_defs.svh"

package frontend_pkg;

    typedef enum logic [0:0] {
        RUN,
        MISS
    } fetch_state_t;

    typedef enum logic [1:0] {
        IDLE,
        GRANT_DATA,
        GRANT_INST
    } arb_state_t;

    // one fetched word with its pc and sequence number
    typedef struct packed {
        logic [`ORDER_W-1:0] order;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    inst;
    } fetch_entry_t;

endpackage

`default_nettype wire

/* rtl/line_if.sv */
`default_nettype none

`include "frontend_defs.svh"

// read and addr held until the resp pulse
interface line_if;
    logic               read;
    logic [`XLEN-1:0]   addr;
    logic [`LINE_W-1:0] rdata;
    logic               resp;

    modport requester (
        output read,
        output addr,
        input  rdata,
        input  resp
    );

    modport provider (
        input  read,
        input  addr,
        output rdata,
        output resp
    );
endinterface

`default_nettype wire

/* rtl/burst_assembler.sv */
`default_nettype none

`include "frontend_defs.svh"

module burst_assembler (
    input  wire logic             clk,
    input  wire logic             rst,
    output logic [`XLEN-1:0]      bmem_addr_o,
    output logic                  bmem_read_o,
    input  wire logic             bmem_ready_i,
    input  wire logic [`BEAT_W-1:0] bmem_rdata_i,
    input  wire logic             bmem_rvalid_i,
    line_if.provider              line
);
    localparam int CNT_W = $clog2(`BEATS_PER_LINE);

    logic               busy_q;
    logic               resp_q;
    logic [CNT_W-1:0]   beat_cnt_q;
    logic [`LINE_W-1:0] line_q;
    logic [`XLEN-1:0]   addr_q;
    logic               start;
    logic               beat_en;
    logic               last_beat;

    assign start     = !busy_q && line.read;
    // beats only count once the read has been accepted
    assign beat_en   = busy_q && !bmem_read_o && bmem_rvalid_i;
    assign last_beat = beat_en && (beat_cnt_q == CNT_W'(`BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            bmem_read_o <= 1'b0;
            resp_q      <= 1'b0;
            beat_cnt_q  <= '0;
        end else begin
            resp_q <= last_beat;
            if (start) begin
                busy_q      <= 1'b1;
                bmem_read_o <= 1'b1;
            end else if (bmem_read_o && bmem_ready_i) begin
                bmem_read_o <= 1'b0;
            end
            if (beat_en) begin
                beat_cnt_q <= last_beat ? '0 : beat_cnt_q + CNT_W'(1);
            end
            // requester still holds read during resp
            if (resp_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= line.addr;
        end
        // beat 0 ends up in the low bits
        if (beat_en) begin
            line_q <= {bmem_rdata_i, line_q[`LINE_W-1:`BEAT_W]};
        end
    end

    assign bmem_addr_o = addr_q;
    assign line.rdata  = line_q;
    assign line.resp   = resp_q;

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`default_nettype none

`include "frontend_defs.svh"

module mem_arbiter
    import frontend_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               dline_read_i,
    input  wire logic [`XLEN-1:0]   dline_addr_i,
    output logic [`LINE_W-1:0]      dline_rdata_o,
    output logic                    dline_resp_o,
    line_if.provider                inst,
    line_if.requester               mem
);
    arb_state_t state_q;
    arb_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // data side wins a tie
                if (dline_read_i) begin
                    state_d = GRANT_DATA;
                end else if (inst.read) begin
                    state_d = GRANT_INST;
                end
            end
            GRANT_DATA, GRANT_INST: begin
                if (mem.resp) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // only the granted side reaches memory
    assign mem.read = ((state_q == GRANT_DATA) && dline_read_i) ||
                      ((state_q == GRANT_INST) && inst.read);
    assign mem.addr = (state_q == GRANT_INST) ? inst.addr : dline_addr_i;

    assign dline_rdata_o = mem.rdata;
    assign inst.rdata    = mem.rdata;
    assign dline_resp_o  = (state_q == GRANT_DATA) && mem.resp;
    assign inst.resp     = (state_q == GRANT_INST) && mem.resp;

endmodule

`default_nettype wire

/* rtl/line_buffer.sv */
`default_nettype none

`include "frontend_defs.svh"

module line_buffer (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               fill_i,
    input  wire logic [`LINE_W-1:0] fill_line_i,
    input  wire logic [`XLEN-1:0]   fill_addr_i,
    input  wire logic [`XLEN-1:0]   pc_i,
    output logic                    hit_o,
    output logic [`XLEN-1:0]        word_o
);
    localparam int OFF_W = $clog2(`LINE_W / 8);

    logic [`LINE_W-1:0]     line_q;
    logic [`XLEN-1:OFF_W]   tag_q;
    logic                   valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fill_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            line_q <= fill_line_i;
            tag_q  <= fill_addr_i[`XLEN-1:OFF_W];
        end
    end

    assign hit_o  = valid_q && (tag_q == pc_i[`XLEN-1:OFF_W]);
    // word index from pc bits 4 to 2
    assign word_o = line_q[pc_i[OFF_W-1:2] * `XLEN +: `XLEN];

endmodule

`default_nettype wire

/* rtl/inst_queue.sv */
`default_nettype none

`include "frontend_defs.svh"

module inst_queue
    import frontend_pkg::*;
#(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           flush_i,
    input  wire logic           enq_i,
    input  wire fetch_entry_t   entry_i,
    output logic                full_o,
    input  wire logic           deq_i,
    output fetch_entry_t        entry_o,
    output logic                empty_o
);
    localparam int PTR_W = $clog2(DEPTH);

    fetch_entry_t       mem_q [DEPTH];
    logic [PTR_W-1:0]   head_q;
    logic [PTR_W-1:0]   tail_q;
    logic [PTR_W:0]     count_q;
    logic               do_enq;
    logic               do_deq;

    assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_enq  = enq_i && !full_o;
    assign do_deq  = deq_i && !empty_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_enq) begin
                tail_q <= tail_q + PTR_W'(1);
            end
            if (do_deq) begin
                head_q <= head_q + PTR_W'(1);
            end
            count_q <= count_q + (PTR_W+1)'(do_enq) - (PTR_W+1)'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem_q[tail_q] <= entry_i;
        end
    end

    // head shown without latency
    assign entry_o = mem_q[head_q];

endmodule

`default_nettype wire

/* rtl/fetch_ctrl.sv */
`default_nettype none

`include "frontend_defs.svh"

module fetch_ctrl
    import frontend_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               redirect_i,
    input  wire logic [`XLEN-1:0]   redirect_pc_i,
    input  wire logic               hit_i,
    input  wire logic [`XLEN-1:0]   word_i,
    output logic [`XLEN-1:0]        pc_o,
    input  wire logic               full_i,
    output logic                    enq_o,
    output fetch_entry_t            entry_o,
    line_if.requester               line
);
    localparam int OFF_W = $clog2(`LINE_W / 8);

    fetch_state_t           state_q;
    logic [`XLEN-1:0]       pc_q;
    logic [`ORDER_W-1:0]    order_q;
    logic                   read_q;
    logic [`XLEN-1:0]       addr_q;
    logic                   start_miss;

    // redirect beats an enqueue in the same cycle
    assign enq_o      = (state_q == RUN) && hit_i && !full_i && !redirect_i;
    assign start_miss = (state_q == RUN) && !hit_i && !redirect_i;

    assign entry_o.order = order_q;
    assign entry_o.pc    = pc_q;
    assign entry_o.inst  = word_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= RUN;
            pc_q    <= `FETCH_RESET_PC;
            order_q <= '0;
            read_q  <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end
            case (state_q)
                RUN: begin
                    if (enq_o) begin
                        pc_q    <= pc_q + `XLEN'(4);
                        order_q <= order_q + `ORDER_W'(1);
                    end else if (start_miss) begin
                        read_q  <= 1'b1;
                        state_q <= MISS;
                    end
                end
                MISS: begin
                    // fill always completes, even after a redirect
                    if (line.resp) begin
                        read_q  <= 1'b0;
                        state_q <= RUN;
                    end
                end
                default: begin
                    state_q <= RUN;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_miss) begin
            addr_q <= {pc_q[`XLEN-1:OFF_W], {OFF_W{1'b0}}};
        end
    end

    assign pc_o      = pc_q;
    assign line.read = read_q;
    assign line.addr = addr_q;

endmodule

`default_nettype wire

/* rtl/fetch_frontend.sv */
`default_nettype none

`include "frontend_defs.svh"

module fetch_frontend
    import frontend_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               redirect_i,
    input  wire logic [`XLEN-1:0]   redirect_pc_i,
    input  wire logic               deq_i,
    output logic                    inst_valid_o,
    output logic [`XLEN-1:0]        inst_o,
    output logic [`XLEN-1:0]        inst_pc_o,
    output logic [`ORDER_W-1:0]     inst_order_o,
    input  wire logic               dline_read_i,
    input  wire logic [`XLEN-1:0]   dline_addr_i,
    output logic [`LINE_W-1:0]      dline_rdata_o,
    output logic                    dline_resp_o,
    output logic [`XLEN-1:0]        bmem_addr_o,
    output logic                    bmem_read_o,
    input  wire logic               bmem_ready_i,
    input  wire logic [`BEAT_W-1:0] bmem_rdata_i,
    input  wire logic               bmem_rvalid_i
);
    line_if inst_line ();
    line_if mem_line ();

    logic               hit;
    logic [`XLEN-1:0]   word;
    logic [`XLEN-1:0]   pc;
    logic               full;
    logic               empty;
    logic               enq;
    fetch_entry_t       enq_entry;
    fetch_entry_t       head_entry;

    burst_assembler u_burst (
        .clk          (clk),
        .rst          (rst),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_ready_i (bmem_ready_i),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .line         (mem_line.provider)
    );

    mem_arbiter u_arb (
        .clk          (clk),
        .rst          (rst),
        .dline_read_i (dline_read_i),
        .dline_addr_i (dline_addr_i),
        .dline_rdata_o(dline_rdata_o),
        .dline_resp_o (dline_resp_o),
        .inst         (inst_line.provider),
        .mem          (mem_line.requester)
    );

    // filled straight from the instruction line response
    line_buffer u_lbuf (
        .clk        (clk),
        .rst        (rst),
        .fill_i     (inst_line.resp),
        .fill_line_i(inst_line.rdata),
        .fill_addr_i(inst_line.addr),
        .pc_i       (pc),
        .hit_o      (hit),
        .word_o     (word)
    );

    inst_queue #(
        .DEPTH(`IQ_DEPTH)
    ) u_iq (
        .clk    (clk),
        .rst    (rst),
        .flush_i(redirect_i),
        .enq_i  (enq),
        .entry_i(enq_entry),
        .full_o (full),
        .deq_i  (deq_i),
        .entry_o(head_entry),
        .empty_o(empty)
    );

    fetch_ctrl u_fetch (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .hit_i        (hit),
        .word_i       (word),
        .pc_o         (pc),
        .full_i       (full),
        .enq_o        (enq),
        .entry_o      (enq_entry),
        .line         (inst_line.requester)
    );

    assign inst_valid_o = !empty;
    assign inst_o       = head_entry.inst;
    assign inst_pc_o    = head_entry.pc;
    assign inst_order_o = head_entry.order;

endmodule

`default_nettype wire

/* bench/fetch_frontend_sva.sv */
`default_nettype none

`include "frontend_defs.svh"

module fetch_frontend_sva (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             redirect_i,
    input wire logic             dline_read_i,
    input wire logic             dline_resp_o,
    input wire logic             inst_valid_o,
    input wire logic             bmem_read_o,
    input wire logic             bmem_ready_i,
    input wire logic [`XLEN-1:0] bmem_addr_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    // outputs quiet right after reset
    reset_quiet: assert property (@(posedge clk)
        rst |=> !bmem_read_o && !dline_resp_o && !inst_valid_o)
        else begin
            $error("bmem_read_o, dline_resp_o or inst_valid_o high after reset");
            fail_cnt++;
        end

    // a stalled read keeps its address
    bmem_hold: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o && !bmem_ready_i |=> bmem_read_o && $stable(bmem_addr_o))
        else begin
            $error("bmem read or address changed while bmem_ready_i was low");
            fail_cnt++;
        end

    dresp_in_read: assert property (@(posedge clk) disable iff (rst)
        dline_resp_o |-> dline_read_i)
        else begin
            $error("dline_resp_o without a pending data read");
            fail_cnt++;
        end

    dresp_pulse: assert property (@(posedge clk) disable iff (rst)
        dline_resp_o |=> !dline_resp_o)
        else begin
            $error("dline_resp_o longer than one cycle");
            fail_cnt++;
        end

    // queue is empty the cycle after a redirect
    flush_empties: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> !inst_valid_o)
        else begin
            $error("instruction queue not empty after redirect");
            fail_cnt++;
        end

endmodule

bind fetch_frontend fetch_frontend_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .redirect_i  (redirect_i),
    .dline_read_i(dline_read_i),
    .dline_resp_o(dline_resp_o),
    .inst_valid_o(inst_valid_o),
    .bmem_read_o (bmem_read_o),
    .bmem_ready_i(bmem_ready_i),
    .bmem_addr_o (bmem_addr_o)
);

`default_nettype wire

/* bench/fetch_frontend_tb.sv */
`default_nettype none

`include "frontend_defs.svh"

module fetch_frontend_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_TESTS = 5;
    localparam logic [31:0] SEED      = 32'h8a55_4505;

    logic                clk;
    logic                rst;
    logic                redirect_i;
    logic [`XLEN-1:0]    redirect_pc_i;
    logic                deq_i;
    logic                inst_valid_o;
    logic [`XLEN-1:0]    inst_o;
    logic [`XLEN-1:0]    inst_pc_o;
    logic [`ORDER_W-1:0] inst_order_o;
    logic                dline_read_i;
    logic [`XLEN-1:0]    dline_addr_i;
    logic [`LINE_W-1:0]  dline_rdata_o;
    logic                dline_resp_o;
    logic [`XLEN-1:0]    bmem_addr_o;
    logic                bmem_read_o;
    logic                bmem_ready_i;
    logic [`BEAT_W-1:0]  bmem_rdata_i;
    logic                bmem_rvalid_i;

    int                  errors = 0;
    int                  errors_at_start = 0;
    int                  tests_done = 0;
    int                  deq_count = 0;
    logic                deq_en = 1'b0;
    logic [`XLEN-1:0]    target;
    logic [`XLEN-1:0]    burst_addr;
    int                  beats_left;
    int                  beat_idx;
    logic                have_prev = 1'b0;
    logic                jumped = 1'b0;
    logic [`XLEN-1:0]    prev_pc;
    logic [`XLEN-1:0]    jump_pc;
    logic [`ORDER_W-1:0] prev_order;

    fetch_frontend DUT (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .deq_i        (deq_i),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .inst_order_o (inst_order_o),
        .dline_read_i (dline_read_i),
        .dline_addr_i (dline_addr_i),
        .dline_rdata_o(dline_rdata_o),
        .dline_resp_o (dline_resp_o),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_ready_i (bmem_ready_i),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i)
    );

    // word at byte address A is A xor 5a5a5a5a
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    function automatic logic [63:0] beat_data(input logic [31:0] line_addr, input int idx);
        return {mem_word(line_addr + 8 * idx + 4), mem_word(line_addr + 8 * idx)};
    endfunction

    function automatic logic [31:0] rand_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    function automatic int total_errors();
        return errors + DUT.u_sva.fail_cnt;
    endfunction

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        int now_errors;
        now_errors = total_errors();
        tests_done++;
        if (now_errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d failed checks", name, now_errors - errors_at_start);
        end
        errors_at_start = now_errors;
    endtask

    task automatic wait_deq(input int n);
        int goal;
        goal = deq_count + n;
        while (deq_count < goal) @(posedge clk);
    endtask

    task automatic redirect_to(input logic [`XLEN-1:0] pc);
        @(posedge clk);
        redirect_i    <= 1'b1;
        redirect_pc_i <= pc;
        @(posedge clk);
        redirect_i    <= 1'b0;
    endtask

    task automatic data_read(input logic [`XLEN-1:0] addr);
        int i;
        @(posedge clk);
        dline_read_i <= 1'b1;
        dline_addr_i <= addr;
        @(posedge clk);
        while (!dline_resp_o) @(posedge clk);
        for (i = 0; i < `LINE_W / `XLEN; i++) begin
            expect_equal("dline_rdata_o", dline_rdata_o[i*`XLEN +: `XLEN],
                         mem_word(addr + 4 * i));
        end
        dline_read_i <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // burst memory with random ready drops and beat gaps
    always @(posedge clk) begin
        if (rst) begin
            bmem_ready_i  <= 1'b0;
            bmem_rvalid_i <= 1'b0;
            beats_left    <= 0;
        end else begin
            bmem_ready_i  <= ($urandom_range(3) != 0);
            bmem_rvalid_i <= 1'b0;
            if (bmem_read_o && bmem_ready_i) begin
                burst_addr <= bmem_addr_o;
                beat_idx   <= 0;
                beats_left <= `BEATS_PER_LINE;
            end else if (beats_left != 0 && $urandom_range(2) != 0) begin
                bmem_rvalid_i <= 1'b1;
                bmem_rdata_i  <= beat_data(burst_addr, beat_idx);
                beat_idx      <= beat_idx + 1;
                beats_left    <= beats_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            deq_i <= 1'b0;
        end else begin
            deq_i <= deq_en && ($urandom_range(3) != 0);
        end
    end

    // every dequeued word against the content rule and the pc/order sequence
    always @(posedge clk) begin
        if (!rst && deq_i && inst_valid_o) begin
            expect_equal("inst_o", inst_o, mem_word(inst_pc_o));
            if (jumped) begin
                expect_equal("inst_pc_o", inst_pc_o, jump_pc);
                if (have_prev) begin
                    assert (inst_order_o > prev_order) else begin
                        errors++;
                        $display("mismatch inst_order_o: got %h expected above %h",
                                 inst_order_o, prev_order);
                    end
                end
            end else if (have_prev) begin
                expect_equal("inst_pc_o", inst_pc_o, 32'(prev_pc + 32'd4));
                expect_equal("inst_order_o", inst_order_o, prev_order + 64'd1);
            end else begin
                expect_equal("inst_pc_o", inst_pc_o, `FETCH_RESET_PC);
            end
            have_prev  = 1'b1;
            jumped     = 1'b0;
            prev_pc    = inst_pc_o;
            prev_order = inst_order_o;
            deq_count <= deq_count + 1;
        end
        if (!rst && redirect_i) begin
            jumped  = 1'b1;
            jump_pc = redirect_pc_i;
        end
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 NUM_TESTS * 2000);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst           <= 1'b1;
        redirect_i    <= 1'b0;
        redirect_pc_i <= '0;
        deq_i         <= 1'b0;
        dline_read_i  <= 1'b0;
        dline_addr_i  <= '0;
        bmem_ready_i  <= 1'b0;
        bmem_rdata_i  <= '0;
        bmem_rvalid_i <= 1'b0;
        repeat (4) @(posedge clk);
        expect_equal("bmem_read_o", bmem_read_o, 0);
        expect_equal("dline_resp_o", dline_resp_o, 0);
        expect_equal("inst_valid_o", inst_valid_o, 0);
        rst    <= 1'b0;
        deq_en <= 1'b1;
        wait_deq(1);
        report_test("reset");

        // eight lines of straight-line fetch
        wait_deq(64);
        report_test("sequential");

        repeat (6) begin
            repeat ($urandom_range(40, 5)) @(posedge clk);
            redirect_to(rand_pc());
            wait_deq(3);
        end
        // second redirect lands while the first fill is still outstanding
        redirect_to(rand_pc());
        repeat (3) @(posedge clk);
        redirect_to(rand_pc());
        wait_deq(3);
        report_test("redirect");

        repeat (12) begin
            repeat ($urandom_range(20)) @(posedge clk);
            data_read($urandom & 32'hffff_ffe0);
        end
        report_test("data reads");

        deq_en <= 1'b0;
        @(posedge clk);
        target = rand_pc();
        redirect_to(target);
        repeat (200) @(posedge clk);
        assert (inst_valid_o) else begin
            errors++;
            $display("queue is empty after holding deq_i low");
        end
        expect_equal("fetch pc", DUT.pc, 32'(target + 4 * `IQ_DEPTH));
        deq_en <= 1'b1;
        wait_deq(2 * `IQ_DEPTH);
        report_test("back-pressure");

        $display("tests run: %0d, failed checks: %0d", tests_done, total_errors());
        if (total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/frontend_pkg.sv
rtl/line_if.sv
rtl/burst_assembler.sv
rtl/mem_arbiter.sv
rtl/line_buffer.sv
rtl/inst_queue.sv
rtl/fetch_ctrl.sv
rtl/fetch_frontend.sv
bench/fetch_frontend_sva.sv
bench/fetch_frontend_tb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/frontend_pkg.sv
      - rtl/line_if.sv
      - rtl/burst_assembler.sv
      - rtl/mem_arbiter.sv
      - rtl/line_buffer.sv
      - rtl/inst_queue.sv
      - rtl/fetch_ctrl.sv
      - rtl/fetch_frontend.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/fetch_frontend_sva.sv
      - bench/fetch_frontend_tb.sv
